//--- include/vga_config.svh
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Raster timing, 640x480 frame with 400 displayed lines
////////////////////////////////////////////////////////////////////////////
`define H_TOTAL     800      // Cycles per line
`define H_DISP      640      // Active pixels
`define HS_START    656      // HS low from here
`define HS_END      751      // Through here
`define V_TOTAL     525      // Lines per frame
`define V_DISP      400      // Active lines
`define VS_START    490
`define VS_END      491

////////////////////////////////////////////////////////////////////////////
// Row fetch and CRTC defaults
////////////////////////////////////////////////////////////////////////////
`define FETCH_HCNT  648      // Trigger point in hblank
`define ROW_CHARS   80       // Bytes per text row
`define TEXT_BASE   15'h7300 // Text area in main memory
`define LPC_RESET   9        // 10 lines per row
`define CURS_OFF_Y  31       // Parked cursor row
`define PIPE_LAT    2        // Beam position to pins

`endif

//--- hdl/crtc_pkg.sv
package crtc_pkg;

   // Command bytes seen with crtc_adr high
   typedef enum logic [7:0] {
      cmd_reset     = 8'h00,  // Followed by five parameters
      cmd_curs_off  = 8'h80,
      cmd_curs_load = 8'h81   // X then Y
   } crtc_cmd_e;

   typedef logic [2:0] crtc_seq_t;  // Parameter countdown
   typedef logic [3:0] lpc_t;       // Last line index of a row
   typedef logic [6:0] col_t;       // Cell column
   typedef logic [4:0] row_t;       // Character row

endpackage

//--- hdl/raster_pkg.sv
package raster_pkg;

   // Beam counters
   typedef logic [9:0] hcnt_t;
   typedef logic [9:0] vcnt_t;

   // Position inside a character cell
   typedef logic [2:0] pix_t;   // Dot within cell
   typedef logic [3:0] line_t;  // Line within row

   // Main memory address for DMA
   typedef logic [14:0] ram_adr_t;

endpackage

//--- hdl/raster_if.sv
`timescale 1ns/1ps

interface raster_if;
   import crtc_pkg::*;
   import raster_pkg::*;

   col_t  col;       // Current cell column
   pix_t  pix;       // Dot in cell
   line_t line;      // Line in character row
   row_t  row;       // Character row, wraps modulo 32
   logic  disp_en;   // Inside 640x400
   logic  hs;        // Raw syncs, active low
   logic  vs;
   logic  row_go;    // Fetch next row
   logic  frame_go;  // Fetch row 0

   modport src (output col, pix, line, row, disp_en, hs, vs, row_go, frame_go);
   modport dst (input  col, pix, line, row, disp_en, hs, vs, row_go, frame_go);

endinterface

//--- hdl/crt_regs.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module crt_regs (
   input  logic             I_CLK,
   input  logic             I_RST,
   input  logic             crtc_we,
   input  logic             crtc_adr,   // High selects command
   input  logic [7:0]       crtc_data,
   output crtc_pkg::lpc_t   lpc,
   output crtc_pkg::col_t   curs_x,
   output crtc_pkg::row_t   curs_y
);
   import crtc_pkg::*;

   crtc_seq_t seq;   // Parameters still expected, 0 is idle
   crtc_cmd_e cmd;

   assign cmd = crtc_cmd_e'(crtc_data);

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         seq    <= '0;
         lpc    <= lpc_t'(`LPC_RESET);
         curs_x <= '0;
         curs_y <= '0;
      end else if (crtc_we) begin
         if (crtc_adr) begin
            case (cmd)
               cmd_reset:     seq    <= 3'd5;               // Five params
               cmd_curs_load: seq    <= 3'd7;               // X at 7, Y at 6
               cmd_curs_off:  curs_y <= row_t'(`CURS_OFF_Y); // Off screen
               default: ;
            endcase
         end else begin
            // Third reset parameter
            if (seq == 3'd3) lpc <= crtc_data[3:0];
            if (seq == 3'd7) curs_x <= crtc_data[6:0];
            if (seq == 3'd6) curs_y <= crtc_data[4:0];
            // Cursor load ends after Y
            if (seq != '0) seq <= (seq == 3'd6) ? '0 : seq - 3'd1;
         end
      end
   end

endmodule

//--- hdl/raster_timing.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module raster_timing (
   input  logic            I_CLK,
   input  logic            I_RST,
   input  crtc_pkg::lpc_t  lpc,
   raster_if.src           rif
);
   import raster_pkg::*;

   hcnt_t hcnt;
   vcnt_t vcnt;
   line_t line_cnt;
   logic [4:0] row_cnt;
   logic  h_last;
   logic  v_last;
   logic  fetch_pt;
   vcnt_t next_row_v;   // First line of the following row

   assign h_last   = (hcnt == hcnt_t'(`H_TOTAL - 1));
   assign v_last   = (vcnt == vcnt_t'(`V_TOTAL - 1));
   assign fetch_pt = (hcnt == hcnt_t'(`FETCH_HCNT));

   ////////////////////////////////////////////////////////////////////////////
   // Beam counters
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         hcnt <= '0;
         vcnt <= '0;
      end else if (h_last) begin
         hcnt <= '0;
         vcnt <= v_last ? '0 : vcnt + 10'd1;
      end else begin
         hcnt <= hcnt + 10'd1;
      end
   end

   // Line in row and row, stepped at end of each scan line
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         line_cnt <= '0;
         row_cnt  <= '0;
      end else if (h_last) begin
         if (v_last) begin
            line_cnt <= '0;          // New frame
            row_cnt  <= '0;
         end else if (line_cnt == lpc) begin
            line_cnt <= '0;
            row_cnt  <= row_cnt + 5'd1;  // Wraps modulo 32
         end else begin
            line_cnt <= line_cnt + 4'd1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Decodes
   ////////////////////////////////////////////////////////////////////////////
   assign next_row_v = vcnt + vcnt_t'(lpc) + 10'd1;

   assign rif.col     = hcnt[9:3];
   assign rif.pix     = hcnt[2:0];
   assign rif.line    = line_cnt;
   assign rif.row     = row_cnt;
   assign rif.disp_en = (hcnt < hcnt_t'(`H_DISP)) && (vcnt < vcnt_t'(`V_DISP));
   assign rif.hs = !((hcnt >= hcnt_t'(`HS_START)) && (hcnt <= hcnt_t'(`HS_END)));
   assign rif.vs = !((vcnt >= vcnt_t'(`VS_START)) && (vcnt <= vcnt_t'(`VS_END)));

   // Row 0 is fetched in vblank, the rest one row ahead
   assign rif.frame_go = fetch_pt && (vcnt == vcnt_t'(`V_DISP));
   assign rif.row_go   = fetch_pt && (line_cnt == '0) &&
                         (next_row_v < vcnt_t'(`V_DISP));

endmodule

//--- hdl/row_fetch.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module row_fetch (
   input  logic                  I_CLK,
   input  logic                  I_RST,
   input  logic                  busack,
   input  logic [7:0]            ram_data,
   raster_if.dst                 rif,
   output raster_pkg::ram_adr_t  ram_adr,
   output logic                  busreq,
   output logic [7:0]            cell_byte
);
   import crtc_pkg::*;

   logic [7:0] row_buf [2][`ROW_CHARS];  // Two banks, one per row parity
   col_t xfer_cnt;    // Bytes taken in this row
   logic wr_bank;     // Bank being filled
   logic accept;      // Byte on ram_data is valid
   logic last_byte;

   assign accept    = busreq & busack;
   assign last_byte = (xfer_cnt == col_t'(`ROW_CHARS - 1));

   ////////////////////////////////////////////////////////////////////////////
   // DMA sequencer
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         busreq   <= 1'b0;
         xfer_cnt <= '0;
         wr_bank  <= 1'b0;
         ram_adr  <= `TEXT_BASE;
      end else begin
         if (rif.frame_go) begin
            busreq   <= 1'b1;          // Row 0 into bank 0
            xfer_cnt <= '0;
            wr_bank  <= 1'b0;
            ram_adr  <= `TEXT_BASE;    // Restart at top of text
         end else if (rif.row_go) begin
            busreq   <= 1'b1;
            xfer_cnt <= '0;
            wr_bank  <= ~rif.row[0];   // Opposite of displayed row
         end else if (accept) begin
            ram_adr  <= ram_adr + 15'd1;
            xfer_cnt <= xfer_cnt + 7'd1;
            if (last_byte) busreq <= 1'b0;  // Release bus after 80th byte
         end
         // busack low simply stalls with busreq held
      end
   end

   // Buffer write, address is the transfer count
   always_ff @(posedge I_CLK) begin
      if (accept) begin
         row_buf[wr_bank][xfer_cnt] <= ram_data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Cell read
   ////////////////////////////////////////////////////////////////////////////
   // Holds past column 79, output is blanked there anyway
   always_ff @(posedge I_CLK) begin
      if (rif.col < col_t'(`ROW_CHARS)) begin
         cell_byte <= row_buf[rif.row[0]][rif.col];
      end
   end

endmodule

//--- hdl/cell_render.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module cell_render (
   input  logic            I_CLK,
   input  logic            I_RST,
   input  logic [7:0]      cell_byte,
   input  crtc_pkg::col_t  curs_x,
   input  crtc_pkg::row_t  curs_y,
   raster_if.dst           rif,
   output logic [3:0]      vga_r,
   output logic [3:0]      vga_g,
   output logic [3:0]      vga_b,
   output logic            vga_hs,
   output logic            vga_vs
);
   import crtc_pkg::*;
   import raster_pkg::*;

   // Beam position delayed to line up with cell_byte
   col_t  col_d;
   row_t  row_d;
   pix_t  pix_d;
   line_t line_d;
   logic  disp_d;

   logic [`PIPE_LAT-1:0] hs_pipe;  // Sync delay to pin
   logic [`PIPE_LAT-1:0] vs_pipe;

   logic dot_sel;
   logic curs_hit;
   logic dot_on;

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         col_d  <= '0;
         row_d  <= '0;
         pix_d  <= '0;
         line_d <= '0;
         disp_d <= 1'b0;
      end else begin
         col_d  <= rif.col;
         row_d  <= rif.row;
         pix_d  <= rif.pix;
         line_d <= rif.line;
         disp_d <= rif.disp_en;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Semigraphic dot and cursor
   ////////////////////////////////////////////////////////////////////////////
   // Left half takes low nibble, right half high, two lines per bit
   assign dot_sel  = cell_byte[{pix_d[2], line_d[2:1]}];
   assign curs_hit = (col_d == curs_x) && (row_d == curs_y);
   // Lines 8 and up are blank gap, cursor still covers them
   assign dot_on   = ((dot_sel & ~line_d[3]) ^ curs_hit) & disp_d;

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         vga_r   <= '0;
         vga_g   <= '0;
         vga_b   <= '0;
         hs_pipe <= '1;   // Syncs idle high
         vs_pipe <= '1;
      end else begin
         vga_r   <= {4{dot_on}};  // Mono white
         vga_g   <= {4{dot_on}};
         vga_b   <= {4{dot_on}};
         hs_pipe <= {hs_pipe[`PIPE_LAT-2:0], rif.hs};
         vs_pipe <= {vs_pipe[`PIPE_LAT-2:0], rif.vs};
      end
   end

   assign vga_hs = hs_pipe[`PIPE_LAT-1];
   assign vga_vs = vs_pipe[`PIPE_LAT-1];

endmodule

//--- hdl/vga_text_top.sv
`timescale 1ns/1ps

module vga_text_top (
   input  logic                  I_CLK,
   input  logic                  I_RST,
   input  logic                  crtc_we,
   input  logic                  crtc_adr,
   input  logic [7:0]            crtc_data,
   input  logic                  busack,
   input  logic [7:0]            ram_data,
   output raster_pkg::ram_adr_t  ram_adr,
   output logic                  busreq,
   output logic [3:0]            vga_r,
   output logic [3:0]            vga_g,
   output logic [3:0]            vga_b,
   output logic                  vga_hs,
   output logic                  vga_vs
);
   import crtc_pkg::*;

   lpc_t       lpc;
   col_t       curs_x;
   row_t       curs_y;
   logic [7:0] cell_byte;   // Byte under the beam, one cycle late

   raster_if rif ();

   ////////////////////////////////////////////////////////////////////////////
   // Register file, timing, fetch and pixel path
   ////////////////////////////////////////////////////////////////////////////
   crt_regs regs0 (
      .I_CLK(I_CLK), .I_RST(I_RST),
      .crtc_we(crtc_we), .crtc_adr(crtc_adr), .crtc_data(crtc_data),
      .lpc(lpc), .curs_x(curs_x), .curs_y(curs_y)
   );

   raster_timing timing0 (.I_CLK(I_CLK), .I_RST(I_RST), .lpc(lpc), .rif(rif.src));

   row_fetch fetch0 (
      .I_CLK(I_CLK), .I_RST(I_RST),
      .busack(busack), .ram_data(ram_data), .rif(rif.dst),
      .ram_adr(ram_adr), .busreq(busreq), .cell_byte(cell_byte)
   );

   cell_render render0 (
      .I_CLK(I_CLK), .I_RST(I_RST),
      .cell_byte(cell_byte), .curs_x(curs_x), .curs_y(curs_y), .rif(rif.dst),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
   );

endmodule

//--- verification/tb_vga_text.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module tb_vga_text;

   localparam int CYC_LIMIT = 4 * 420000 * 11 / 10;  // Four frames plus margin

   logic        I_CLK = 1'b0;
   logic        I_RST;
   logic        crtc_we;
   logic        crtc_adr;
   logic [7:0]  crtc_data;
   logic        busack;
   logic [7:0]  ram_data;
   logic [14:0] ram_adr;
   logic        busreq;
   logic [3:0]  vga_r;
   logic [3:0]  vga_g;
   logic [3:0]  vga_b;
   logic        vga_hs;
   logic        vga_vs;

   logic [7:0]  mem [0:32767];   // Main memory model
   logic [39:0] stim [0:63];     // Raw stimulus records
   logic [31:0] lcg_state;
   int w_frame[$];               // CRTC writes, applied at line 450
   int w_adr[$];
   int w_data[$];
   int gaps[$];                  // busack low lengths
   int p_frame[$];               // Probe points
   int p_x[$];
   int p_y[$];
   int p_val[$];

   int hx, vy, frame;            // Beam position as the DUT counters hold it
   bit running;
   int m_lpc, m_cx, m_cy, m_seq; // CRTC register model
   int q_pix[2], q_hs[2], q_vs[2], q_chk[2], q_probe[2];  // Two-cycle output delay
   int errors, checks, cycles, wi, gi, gap_left, acc_cnt, probes_hit;
   logic [14:0] exp_adr;
   bit busreq_d, trig_d, drop_d;

   vga_text_top dut0 (
      .I_CLK(I_CLK), .I_RST(I_RST),
      .crtc_we(crtc_we), .crtc_adr(crtc_adr), .crtc_data(crtc_data),
      .busack(busack), .ram_data(ram_data), .ram_adr(ram_adr), .busreq(busreq),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
   );

   assign ram_data = mem[ram_adr];  // Zero wait state read

   initial begin
      forever #4 I_CLK = ~I_CLK;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   // CRTC command rules, applied as each write is driven
   task automatic model_write(input int adr, input int data);
      if (adr != 0) begin
         if (data == 8'h00) m_seq = 5;
         else if (data == 8'h81) m_seq = 7;
         else if (data == 8'h80) m_cy = `CURS_OFF_Y;
      end else begin
         if (m_seq == 3) m_lpc = data & 15;
         if (m_seq == 7) m_cx = data & 127;
         if (m_seq == 6) m_cy = data & 31;
         if (m_seq != 0) m_seq = (m_seq == 6) ? 0 : m_seq - 1;
      end
   endtask

   // Semigraphic cell with cursor inversion
   function automatic int exp_pixel(input int x, input int y);
      int row, line, col, adr, bitn, dot, hit;
      logic [7:0] b;
      if (x >= `H_DISP || y >= `V_DISP) return 0;
      row  = y / (m_lpc + 1);
      line = y % (m_lpc + 1);
      col  = x / 8;
      adr  = (`TEXT_BASE + row * `ROW_CHARS + col) % 32768;
      b    = mem[adr];
      bitn = ((x % 8) >= 4 ? 4 : 0) + line / 2;
      dot  = (line < 8) ? b[bitn & 7] : 0;   // Lines 8 and up are gap
      hit  = ((row % 32) == m_cy) && (col == m_cx);
      return dot ^ hit;
   endfunction

   function automatic int probe_at(input int x, input int y);
      foreach (p_x[i]) begin
         if (p_frame[i] == frame && p_x[i] == x && p_y[i] == y) return p_val[i];
      end
      return -1;
   endfunction

   task automatic end_run();
      if (wi != w_frame.size()) begin
         errors++;
         $display("Not all CRTC writes were applied (%0d of %0d)", wi, w_frame.size());
      end
      if (probes_hit != p_x.size()) begin
         errors++;
         $display("Only %0d of %0d probe points were reached", probes_hit, p_x.size());
      end
      $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Setup and reset
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      logic [3:0] tag;
      I_RST = 1'b1;
      crtc_we = 1'b0;
      crtc_adr = 1'b0;
      crtc_data = 8'h00;
      busack = 1'b0;
      running = 1'b0;
      {hx, vy, frame, errors, checks, cycles, wi, gi, gap_left} = '0;
      {acc_cnt, probes_hit, m_cx, m_cy, m_seq} = '0;
      m_lpc = `LPC_RESET;
      exp_adr = `TEXT_BASE;
      busreq_d = 1'b0;
      trig_d = 1'b0;
      drop_d = 1'b0;
      for (int k = 0; k < 2; k++) begin
         q_pix[k] = 0;      // Reset values until the pipe fills
         q_hs[k] = 1;
         q_vs[k] = 1;
         q_chk[k] = 1;
         q_probe[k] = -1;
      end
      lcg_state = 32'h30a758a8;
      for (int a = 0; a < 32768; a++) begin
         lcg_state = lcg_next(lcg_state);
         mem[a] = lcg_state[23:16] ^ a[7:0] ^ {1'b0, a[14:8]};
      end
      foreach (stim[i]) stim[i] = '0;
      $readmemh("verification/vga_stimulus.txt", stim);
      foreach (stim[i]) begin
         tag = stim[i][39:36];
         if (tag == 4'd0) break;
         case (tag)
            4'd1: begin
               w_frame.push_back(stim[i][35:32]);
               w_adr.push_back(stim[i][31:20]);
               w_data.push_back(stim[i][7:0]);
            end
            4'd2: gaps.push_back(stim[i][7:0]);
            4'd3: mem[stim[i][22:8]] = stim[i][7:0];  // Seed byte
            4'd4: begin
               p_frame.push_back(stim[i][35:32]);
               p_x.push_back(stim[i][31:20]);
               p_y.push_back(stim[i][19:8]);
               p_val.push_back(stim[i][7:0]);
            end
            default: begin
               errors++;
               $display("Unknown stimulus record %0h", stim[i]);
            end
         endcase
      end
      if (w_frame.size() == 0 || p_x.size() == 0) begin
         errors++;
         $display("Stimulus file gave no register writes or no probe points");
      end
      if (gaps.size() == 0) gaps.push_back(0);
      repeat (8) @(posedge I_CLK);
      I_RST <= 1'b0;
      running <= 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Drive on rising edge
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge I_CLK) begin
      if (running) begin
         if (gap_left > 0) begin
            busack <= 1'b0;
            gap_left--;
         end else begin
            busack <= 1'b1;
            gap_left = gaps[gi];
            gi = (gi + 1) % gaps.size();
         end
         if (wi < w_frame.size() && w_frame[wi] == frame && vy == 450) begin
            crtc_we   <= 1'b1;
            crtc_adr  <= w_adr[wi][0];
            crtc_data <= w_data[wi][7:0];
            model_write(w_adr[wi], w_data[wi]);
            wi++;
         end else begin
            crtc_we <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Check on falling edge
   ////////////////////////////////////////////////////////////////////////////
   always @(negedge I_CLK) begin
      if (I_RST) begin
         check_value("vga_hs", vga_hs, 1);
         check_value("vga_vs", vga_vs, 1);
         check_value("vga_r", vga_r, 0);
         check_value("vga_g", vga_g, 0);
         check_value("vga_b", vga_b, 0);
         check_value("busreq", busreq, 0);
      end else if (running) begin
         cycles++;
         if (q_chk[1] != 0) begin
            check_value("vga_r", vga_r, q_pix[1] ? 32'hf : 32'h0);
            check_value("vga_g", vga_g, q_pix[1] ? 32'hf : 32'h0);
            check_value("vga_b", vga_b, q_pix[1] ? 32'hf : 32'h0);
         end
         check_value("vga_hs", vga_hs, q_hs[1]);
         check_value("vga_vs", vga_vs, q_vs[1]);
         if (q_probe[1] >= 0) begin
            check_value("vga_r at probe", vga_r, q_probe[1] ? 32'hf : 32'h0);
            probes_hit++;
         end
         // DMA protocol
         if (trig_d) check_value("busreq after trigger", busreq, 1);
         else if (!busreq_d) check_value("busreq without trigger", busreq, 0);
         if (drop_d) check_value("busreq after last byte", busreq, 0);
         if (busreq && busack) begin
            check_value("ram_adr", ram_adr, exp_adr);
            exp_adr++;
            acc_cnt++;
         end
         drop_d = busreq && busack && (acc_cnt == `ROW_CHARS);  // Bus due back next cycle
         if (busreq_d && !busreq) begin
            check_value("accepted bytes", acc_cnt, `ROW_CHARS);
            acc_cnt = 0;
         end
         busreq_d = busreq;
         trig_d = (hx == `FETCH_HCNT) && ((vy == `V_DISP) ||
                  (vy < `V_DISP && vy % (m_lpc + 1) == 0 && vy + m_lpc + 1 < `V_DISP));
         if (hx == `FETCH_HCNT && vy == `V_DISP) exp_adr = `TEXT_BASE;
         // Expected outputs for the current position
         q_pix[1]   = q_pix[0];
         q_hs[1]    = q_hs[0];
         q_vs[1]    = q_vs[0];
         q_chk[1]   = q_chk[0];
         q_probe[1] = q_probe[0];
         q_pix[0]   = exp_pixel(hx, vy);
         q_hs[0]    = !(hx >= `HS_START && hx <= `HS_END);
         q_vs[0]    = !(vy >= `VS_START && vy <= `VS_END);
         q_chk[0]   = (frame > 0);   // Row 0 of frame 0 is never fetched
         q_probe[0] = probe_at(hx, vy);
         hx++;
         if (hx == `H_TOTAL) begin
            hx = 0;
            vy++;
            if (vy == `V_TOTAL) begin
               vy = 0;
               frame++;
            end
         end
         if (frame >= 4 && !busreq) begin
            end_run();   // Four frames done and the bus released
         end else if (cycles > CYC_LIMIT) begin
            errors++;
            $display("Timeout after %0d cycles", cycles);
            end_run();
         end
      end
   end

endmodule

//--- verification/vga_stimulus.txt
// Columns T F XXX YYY DD. T 1 write (F frame, XXX crtc_adr, DD data), 2 busack gap (DD)
// T 3 memory seed (XXXYYY address, DD byte), T 4 probe (F frame, XXX x, YYY y, DD pixel)
2_0_000_000_00
2_0_000_000_01
2_0_000_000_07
3_0_007_300_5a
3_0_007_3fc_ff
3_0_007_cbc_00
1_1_001_000_81
1_1_000_000_0c
1_1_000_000_03
1_2_001_000_00
1_2_000_000_4f
1_2_000_000_18
1_2_000_000_07
1_2_000_000_00
1_2_000_000_00
1_2_001_000_80
4_1_000_000_01
4_1_000_002_00
4_1_004_000_00
4_1_000_008_01
4_1_060_01e_01
4_2_060_01e_00
4_2_060_026_01
4_3_064_018_01
4_3_060_0f8_01
4_3_000_000_00

//--- vga_text_top.f
+incdir+include
hdl/crtc_pkg.sv
hdl/raster_pkg.sv
hdl/raster_if.sv
hdl/crt_regs.sv
hdl/raster_timing.sv
hdl/row_fetch.sv
hdl/cell_render.sv
hdl/vga_text_top.sv
verification/tb_vga_text.sv

//--- Bender.yml
package:
  name: vga_text

sources:
  - include_dirs:
      - include
    files:
      - hdl/crtc_pkg.sv
      - hdl/raster_pkg.sv
      - hdl/raster_if.sv
      - hdl/crt_regs.sv
      - hdl/raster_timing.sv
      - hdl/row_fetch.sv
      - hdl/cell_render.sv
      - hdl/vga_text_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/tb_vga_text.sv
